// ==== common/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

    typedef logic [31:0] xlen_t;

    // one retired instruction as offered on the retire port
    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
        xlen_t operand;
    } retire_t;

    typedef enum logic [2:0] {
        EV_ECALL   = 3'd0,
        EV_EBREAK  = 3'd1,
        EV_ILLEGAL = 3'd2,
        EV_MRET    = 3'd3,
        EV_CSRRW   = 3'd4
    } ev_kind_e;

    // queued event, csr_addr and wdata only matter for csrrw
    typedef struct packed {
        ev_kind_e    kind;
        xlen_t       pc;
        logic [11:0] csr_addr;
        xlen_t       wdata;
    } trap_ev_t;

    typedef struct packed {
        logic        we;
        logic [11:0] addr;
        xlen_t       data;
    } csr_wr_t;

    // machine-mode subset of mstatus
    typedef struct packed {
        logic [31:8] rsv_hi;
        logic        mpie;
        logic [6:4]  rsv_mid;
        logic        mie;
        logic [2:0]  rsv_lo;
    } mstatus_f_t;

    typedef union packed {
        xlen_t      raw;
        mstatus_f_t fields;
    } mstatus_u;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

    // instruction encodings
    localparam logic [6:0]  OPC_SYSTEM = 7'b111_0011;
    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // machine CSR addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // synchronous exception causes
    localparam xlen_t CAUSE_ILLEGAL    = 32'd2;
    localparam xlen_t CAUSE_BREAKPOINT = 32'd3;
    localparam xlen_t CAUSE_ECALL_M    = 32'd11;

    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage

`default_nettype wire

// ==== rtl/sys_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_decode (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              inst_req_i,
    input  trap_pkg::retire_t      inst_i,
    input  wire logic              full_i,
    output logic                   inst_ack_o,
    output logic                   push_o,
    output trap_pkg::trap_ev_t     ev_o
);
    import trap_pkg::*;

    logic        ack_q;
    logic        accept;
    logic        is_system;
    logic        priv_ok;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign funct3  = inst_i.inst[14:12];
    assign funct12 = inst_i.inst[31:20];

    assign is_system = (inst_i.inst[6:0] == OPC_SYSTEM);

    // ecall, ebreak and mret need rd and rs1 both zero
    assign priv_ok = (funct3 == F3_PRIV) &&
                     (inst_i.inst[11:7] == 5'd0) &&
                     (inst_i.inst[19:15] == 5'd0);

    always_comb begin
        ev_o.pc       = inst_i.pc;
        ev_o.csr_addr = funct12;
        ev_o.wdata    = inst_i.operand;
        if (funct3 == F3_CSRRW) begin
            ev_o.kind = EV_CSRRW;
        end else if (priv_ok && funct12 == F12_ECALL) begin
            ev_o.kind = EV_ECALL;
        end else if (priv_ok && funct12 == F12_EBREAK) begin
            ev_o.kind = EV_EBREAK;
        end else if (priv_ok && funct12 == F12_MRET) begin
            ev_o.kind = EV_MRET;
        end else begin
            ev_o.kind = EV_ILLEGAL;
        end
    end

    // new request, not yet acked, and room in the queue
    assign accept = inst_req_i && !ack_q && !full_i;

    // non-SYSTEM instructions are acked without a push
    assign push_o = accept && is_system;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (ack_q && !inst_req_i) begin
            ack_q <= 1'b0;
        end
    end

    assign inst_ack_o = ack_q;

endmodule

`default_nettype wire

// ==== rtl/event_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_queue (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  wire logic          push_i,
    input  trap_pkg::trap_ev_t ev_i,
    input  wire logic          pop_i,
    output logic               full_o,
    output logic               nonempty_o,
    output trap_pkg::trap_ev_t ev_o
);
    import trap_pkg::*;

    // lets the decoder ack the next instruction while the controller sequences
    trap_ev_t                 mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0]   wr_ptr;
    logic [QUEUE_PTR_W-1:0]   rd_ptr;
    logic [QUEUE_CNT_W-1:0]   count;

    assign full_o     = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign nonempty_o = (count != '0);
    assign ev_o       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= ev_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count unchanged
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== trap_ctrl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  trap_pkg::csr_wr_t  csr_wr_i,
    input  wire logic [11:0]   raddr_i,
    output trap_pkg::xlen_t    rdata_o,
    output trap_pkg::xlen_t    mtvec_o,
    output trap_pkg::xlen_t    mepc_o,
    output trap_pkg::mstatus_u mstatus_o
);
    import trap_pkg::*;

    xlen_t    mtvec_q;
    xlen_t    mepc_q;
    xlen_t    mcause_q;
    mstatus_u mstatus_q;
    mstatus_u mstatus_in;
    mstatus_u mstatus_wr;

    // only mie and mpie are implemented, everything else reads zero
    always_comb begin
        mstatus_in.raw         = csr_wr_i.data;
        mstatus_wr.raw         = '0;
        mstatus_wr.fields.mie  = mstatus_in.fields.mie;
        mstatus_wr.fields.mpie = mstatus_in.fields.mpie;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mtvec_q       <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mstatus_q.raw <= '0;
        end else if (csr_wr_i.we) begin
            case (csr_wr_i.addr)
                // vector base is word aligned, direct mode only
                CSR_MTVEC:   mtvec_q   <= {csr_wr_i.data[31:2], 2'b00};
                CSR_MEPC:    mepc_q    <= {csr_wr_i.data[31:2], 2'b00};
                CSR_MCAUSE:  mcause_q  <= csr_wr_i.data;
                CSR_MSTATUS: mstatus_q <= mstatus_wr;
                default: begin
                    mtvec_q <= mtvec_q;
                end
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            CSR_MTVEC:   rdata_o = mtvec_q;
            CSR_MEPC:    rdata_o = mepc_q;
            CSR_MCAUSE:  rdata_o = mcause_q;
            CSR_MSTATUS: rdata_o = mstatus_q.raw;
            default:     rdata_o = '0;
        endcase
    end

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;

endmodule

`default_nettype wire

// ==== trap_ctrl/trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    input  wire logic           nonempty_i,
    input  trap_pkg::trap_ev_t  ev_i,
    input  trap_pkg::xlen_t     mtvec_i,
    input  trap_pkg::xlen_t     mepc_i,
    input  trap_pkg::mstatus_u  mstatus_i,
    output logic                pop_o,
    output trap_pkg::csr_wr_t   csr_wr_o,
    output trap_pkg::redirect_t redirect_o,
    output logic                busy_o
);
    import trap_pkg::*;

    typedef enum logic [7:0] {
        S_IDLE          = 8'b0000_0001,
        S_MEPC          = 8'b0000_0010,
        S_MSTATUS       = 8'b0000_0100,
        S_MCAUSE        = 8'b0000_1000,
        S_REDIRECT      = 8'b0001_0000,
        S_MRET_STATUS   = 8'b0010_0000,
        S_MRET_REDIRECT = 8'b0100_0000,
        S_CSR_WRITE     = 8'b1000_0000
    } state_e;

    state_e      state_q;
    state_e      state_d;
    xlen_t       pc_q;
    xlen_t       cause_q;
    xlen_t       wdata_q;
    logic [11:0] csr_addr_q;
    xlen_t       ev_cause;
    mstatus_u    mstatus_nxt;

    assign pop_o  = (state_q == S_IDLE) && nonempty_i;
    assign busy_o = (state_q != S_IDLE) || nonempty_i;

    always_comb begin
        case (ev_i.kind)
            EV_ECALL:  ev_cause = CAUSE_ECALL_M;
            EV_EBREAK: ev_cause = CAUSE_BREAKPOINT;
            default:   ev_cause = CAUSE_ILLEGAL;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (nonempty_i) begin
                    case (ev_i.kind)
                        EV_MRET:  state_d = S_MRET_STATUS;
                        EV_CSRRW: state_d = S_CSR_WRITE;
                        EV_ECALL, EV_EBREAK, EV_ILLEGAL: state_d = S_MEPC;
                        // unknown kinds are popped and dropped
                        default:  state_d = S_IDLE;
                    endcase
                end
            end
            S_MEPC:          state_d = S_MSTATUS;
            S_MSTATUS:       state_d = S_MCAUSE;
            S_MCAUSE:        state_d = S_REDIRECT;
            S_REDIRECT:      state_d = S_IDLE;
            S_MRET_STATUS:   state_d = S_MRET_REDIRECT;
            S_MRET_REDIRECT: state_d = S_IDLE;
            S_CSR_WRITE:     state_d = S_IDLE;
            default:         state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // event payload held for the whole sequence
    always_ff @(posedge clk) begin
        if (pop_o) begin
            pc_q       <= ev_i.pc;
            cause_q    <= ev_cause;
            wdata_q    <= ev_i.wdata;
            csr_addr_q <= ev_i.csr_addr;
        end
    end

    // writes and redirects decode straight from the state register
    always_comb begin
        csr_wr_o    = '0;
        redirect_o  = '0;
        mstatus_nxt = mstatus_i;
        case (state_q)
            S_MEPC: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MEPC;
                csr_wr_o.data = pc_q;
            end
            S_MSTATUS: begin
                // trap entry disables interrupts, saving mie in mpie
                mstatus_nxt.fields.mpie = mstatus_i.fields.mie;
                mstatus_nxt.fields.mie  = 1'b0;
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MSTATUS;
                csr_wr_o.data = mstatus_nxt.raw;
            end
            S_MCAUSE: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MCAUSE;
                csr_wr_o.data = cause_q;
            end
            S_REDIRECT: begin
                redirect_o.valid  = 1'b1;
                redirect_o.target = mtvec_i;
            end
            S_MRET_STATUS: begin
                mstatus_nxt.fields.mie  = mstatus_i.fields.mpie;
                mstatus_nxt.fields.mpie = 1'b1;
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = CSR_MSTATUS;
                csr_wr_o.data = mstatus_nxt.raw;
            end
            S_MRET_REDIRECT: begin
                redirect_o.valid  = 1'b1;
                redirect_o.target = mepc_i;
            end
            S_CSR_WRITE: begin
                csr_wr_o.we   = 1'b1;
                csr_wr_o.addr = csr_addr_q;
                csr_wr_o.data = wdata_q;
            end
            default: begin
                csr_wr_o   = '0;
                redirect_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/trap_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    input  wire logic           inst_req_i,
    input  trap_pkg::retire_t   inst_i,
    input  wire logic [11:0]    csr_raddr_i,
    output logic                inst_ack_o,
    output trap_pkg::redirect_t redirect_o,
    output trap_pkg::xlen_t     csr_rdata_o,
    output logic                busy_o
);
    import trap_pkg::*;

    logic     push;
    logic     full;
    logic     nonempty;
    logic     pop;
    trap_ev_t ev_in;
    trap_ev_t ev_out;
    csr_wr_t  csr_wr;
    xlen_t    mtvec;
    xlen_t    mepc;
    mstatus_u mstatus;

    sys_decode u_sys_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .full_i     (full),
        .inst_ack_o (inst_ack_o),
        .push_o     (push),
        .ev_o       (ev_in)
    );

    event_queue u_event_queue (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .push_i     (push),
        .ev_i       (ev_in),
        .pop_i      (pop),
        .full_o     (full),
        .nonempty_o (nonempty),
        .ev_o       (ev_out)
    );

    trap_ctrl u_trap_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .nonempty_i (nonempty),
        .ev_i       (ev_out),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .mstatus_i  (mstatus),
        .pop_o      (pop),
        .csr_wr_o   (csr_wr),
        .redirect_o (redirect_o),
        .busy_o     (busy_o)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .csr_wr_i  (csr_wr),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mstatus_o (mstatus)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // released on a falling edge, away from the active edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/trap_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb;
    import trap_pkg::*;

    localparam int          WAIT_LIMIT   = 100;
    localparam logic [31:0] SEED         = 32'hb5f4_4156;
    localparam logic [31:0] MSTATUS_MASK = 32'h0000_0088;

    // instruction classes seen by the reference model
    localparam int K_NONE    = 0;
    localparam int K_ECALL   = 1;
    localparam int K_EBREAK  = 2;
    localparam int K_ILLEGAL = 3;
    localparam int K_MRET    = 4;
    localparam int K_CSRRW   = 5;

    localparam logic [31:0] INST_ECALL   = 32'h0000_0073;
    localparam logic [31:0] INST_EBREAK  = 32'h0010_0073;
    localparam logic [31:0] INST_MRET    = 32'h3020_0073;
    localparam logic [31:0] INST_ILLEGAL = 32'h7ab0_0073;
    localparam logic [31:0] INST_ADDI    = 32'h02a0_0093;
    localparam logic [31:0] INST_LW      = 32'h0000_a103;

    logic        clk;
    logic        rst_n;
    logic        inst_req_i;
    retire_t     inst_i;
    logic [11:0] csr_raddr_i;
    logic        inst_ack_o;
    redirect_t   redirect_o;
    xlen_t       csr_rdata_o;
    logic        busy_o;

    xlen_t exp_mtvec;
    xlen_t exp_mepc;
    xlen_t exp_mcause;
    xlen_t exp_mstatus;
    xlen_t exp_redirects[$];
    int    errors;
    int    errors_at_start;
    int    test_num;
    int    max_ack_wait;
    bit    aborted;

    tb_clk_gen u_tb_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    trap_unit_top u_trap_unit_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .inst_req_i  (inst_req_i),
        .inst_i      (inst_i),
        .csr_raddr_i (csr_raddr_i),
        .inst_ack_o  (inst_ack_o),
        .redirect_o  (redirect_o),
        .csr_rdata_o (csr_rdata_o),
        .busy_o      (busy_o)
    );

    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.valid |=> !redirect_o.valid)
    else begin
        $display("redirect_o.valid stayed high for more than one cycle");
        errors++;
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (!inst_req_i && !inst_ack_o) |=> !inst_ack_o)
    else begin
        $display("inst_ack_o rose while inst_req_i was low");
        errors++;
    end

    // each redirect pulse is matched against the oldest expected target
    always @(posedge clk) begin
        if (rst_n && redirect_o.valid) begin
            if (exp_redirects.size() == 0) begin
                $display("unexpected redirect to 0x%h with no event pending", redirect_o.target);
                errors++;
            end else begin
                assert (redirect_o.target === exp_redirects[0]) else begin
                    $display("CHECK FAILED redirect_o.target = 0x%h, expected 0x%h",
                             redirect_o.target, exp_redirects[0]);
                    errors++;
                end
                void'(exp_redirects.pop_front());
            end
        end
    end

    function automatic xlen_t encode_csrrw(input logic [11:0] csr);
        return {csr, 5'd1, 3'b001, 5'd0, 7'b111_0011};
    endfunction

    task automatic abort_on_timeout(input string msg);
        $display("%s", msg);
        errors++;
        aborted = 1'b1;
    endtask

    // sequential view of the CSRs, in retire order
    task automatic apply_to_model(input int kind, input xlen_t pc, input logic [11:0] csr,
                                  input xlen_t data);
        case (kind)
            K_ECALL, K_EBREAK, K_ILLEGAL: begin
                exp_mepc    = pc & ~32'h3;
                // mpie takes mie, mie cleared
                exp_mstatus = (exp_mstatus & 32'h8) << 4;
                exp_mcause  = (kind == K_ECALL) ? 32'd11 :
                              (kind == K_EBREAK) ? 32'd3 : 32'd2;
                exp_redirects.push_back(exp_mtvec);
            end
            K_MRET: begin
                exp_mstatus = 32'h80 | ((exp_mstatus & 32'h80) >> 4);
                exp_redirects.push_back(exp_mepc);
            end
            K_CSRRW: begin
                case (csr)
                    CSR_MTVEC:   exp_mtvec   = data & ~32'h3;
                    CSR_MEPC:    exp_mepc    = data & ~32'h3;
                    CSR_MCAUSE:  exp_mcause  = data;
                    CSR_MSTATUS: exp_mstatus = data & MSTATUS_MASK;
                    default:     ;
                endcase
            end
            default: ;
        endcase
    endtask

    // four-phase handshake, req drops as soon as ack is seen
    task automatic retire(input int kind, input xlen_t pc, input xlen_t inst,
                          input xlen_t operand);
        int waited;
        if (aborted) return;
        @(negedge clk);
        waited = 0;
        while (inst_ack_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (inst_ack_o) begin
            abort_on_timeout("timeout: inst_ack_o did not fall after inst_req_i dropped");
            return;
        end
        inst_i.pc      = pc;
        inst_i.inst    = inst;
        inst_i.operand = operand;
        inst_req_i     = 1'b1;
        waited = 0;
        while (!inst_ack_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_ack_o) begin
            abort_on_timeout("timeout: inst_ack_o never rose for a pending request");
            return;
        end
        if (waited > max_ack_wait) max_ack_wait = waited;
        // a kept instruction sits in the queue or the controller
        if (kind != K_NONE) begin
            assert (busy_o === 1'b1) else begin
                $display("CHECK FAILED busy_o = 0x%h, expected 0x1", busy_o);
                errors++;
            end
        end
        apply_to_model(kind, pc, inst[31:20], operand);
        inst_req_i = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        if (aborted) return;
        waited = 0;
        while ((busy_o || inst_ack_o || exp_redirects.size() != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy_o || inst_ack_o || exp_redirects.size() != 0) begin
            abort_on_timeout("timeout: trap unit never went idle or a redirect never came");
        end
    endtask

    task automatic check_csr(input string name, input logic [11:0] addr, input xlen_t exp);
        if (aborted) return;
        @(negedge clk);
        csr_raddr_i = addr;
        @(posedge clk);
        assert (csr_rdata_o === exp) else begin
            $display("CHECK FAILED %s csr_rdata_o = 0x%h, expected 0x%h", name, csr_rdata_o, exp);
            errors++;
        end
    endtask

    task automatic compare_csrs();
        check_csr("mtvec", CSR_MTVEC, exp_mtvec);
        check_csr("mepc", CSR_MEPC, exp_mepc);
        check_csr("mcause", CSR_MCAUSE, exp_mcause);
        check_csr("mstatus", CSR_MSTATUS, exp_mstatus);
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d failed checks", test_num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic reset_and_setup();
        assert (busy_o === 1'b0) else begin
            $display("CHECK FAILED busy_o = 0x%h, expected 0x0", busy_o);
            errors++;
        end
        compare_csrs();
        retire(K_CSRRW, $urandom, encode_csrrw(CSR_MTVEC), $urandom | 32'h1);
        retire(K_CSRRW, $urandom, encode_csrrw(CSR_MEPC), $urandom | 32'h2);
        // mie set, mpie clear, reserved bits random
        retire(K_CSRRW, $urandom, encode_csrrw(CSR_MSTATUS), ($urandom | 32'h8) & ~32'h80);
        wait_idle();
        compare_csrs();
        report_test("reset and csr setup");
    endtask

    task automatic ecall_and_ebreak();
        retire(K_ECALL, $urandom, INST_ECALL, $urandom);
        wait_idle();
        compare_csrs();
        retire(K_EBREAK, $urandom, INST_EBREAK, $urandom);
        wait_idle();
        compare_csrs();
        report_test("ecall and ebreak");
    endtask

    task automatic mret_after_trap();
        retire(K_CSRRW, $urandom, encode_csrrw(CSR_MSTATUS), 32'h8);
        retire(K_ECALL, $urandom, INST_ECALL, $urandom);
        retire(K_MRET, $urandom, INST_MRET, $urandom);
        wait_idle();
        compare_csrs();
        report_test("mret");
    endtask

    task automatic illegal_and_ignored();
        retire(K_ILLEGAL, $urandom, INST_ILLEGAL, $urandom);
        wait_idle();
        compare_csrs();
        retire(K_NONE, $urandom, INST_ADDI, $urandom);
        retire(K_NONE, $urandom, INST_LW, $urandom);
        wait_idle();
        compare_csrs();
        report_test("illegal and ignored instructions");
    endtask

    // pushes every two cycles outrun the five-cycle trap sequence
    task automatic burst_ordering();
        max_ack_wait = 0;
        retire(K_ECALL, $urandom, INST_ECALL, $urandom);
        retire(K_MRET, $urandom, INST_MRET, $urandom);
        retire(K_ECALL, $urandom, INST_ECALL, $urandom);
        retire(K_MRET, $urandom, INST_MRET, $urandom);
        retire(K_ECALL, $urandom, INST_ECALL, $urandom);
        wait_idle();
        if (!aborted) begin
            assert (max_ack_wait > 1) else begin
                $display("back-pressure not seen, inst_ack_o never stalled during the burst");
                errors++;
            end
        end
        compare_csrs();
        report_test("back-pressure and ordering");
    endtask

    initial begin
        int waited;
        inst_req_i      = 1'b0;
        inst_i          = '0;
        csr_raddr_i     = '0;
        exp_mtvec       = '0;
        exp_mepc        = '0;
        exp_mcause      = '0;
        exp_mstatus     = '0;
        errors          = 0;
        errors_at_start = 0;
        test_num        = 0;
        max_ack_wait    = 0;
        aborted         = 1'b0;
        void'($urandom(SEED));
        waited = 0;
        while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) abort_on_timeout("timeout: reset was never released");
        reset_and_setup();
        ecall_and_ebreak();
        mret_after_trap();
        illegal_and_ignored();
        burst_ordering();
        $display("tests run: %0d, failed checks: %0d", test_num, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/trap_pkg.sv
rtl/sys_decode.sv
rtl/event_queue.sv
trap_ctrl/csr_file.sv
trap_ctrl/trap_ctrl.sv
rtl/trap_unit_top.sv
tests/tb_clk_gen.sv
tests/trap_unit_tb.sv
